//--- hdl/usb_rx_pkg.sv
package usb_rx_pkg;

    // PID code nibble, standard USB encodings
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010
    } pid_code_e;

    // Packet class reported at the top level
    typedef enum logic [2:0] {
        PKT_NONE  = 3'd0,
        PKT_OUT   = 3'd1,
        PKT_IN    = 3'd2,
        PKT_DATA0 = 3'd3,
        PKT_DATA1 = 3'd4,
        PKT_ACK   = 3'd5,
        PKT_NAK   = 3'd6,
        PKT_OTHER = 3'd7
    } rx_packet_e;

    // Bits arrive LSB first, so the code lands in the low nibble
    typedef struct packed {
        logic [3:0] check;
        pid_code_e  code;
    } pid_fields_t;

    typedef union packed {
        pid_fields_t pid;
        logic [7:0]  data;
    } rx_byte_u;

    // KJKJKJKK decodes to seven zeros then a one
    localparam logic [7:0] SYNC_PATTERN = 8'h80;

    localparam logic [2:0] STUFF_RUN = 3'd6;

endpackage

//--- hdl/usb_bit_if.sv
`timescale 1ns/1ns

interface usb_bit_if;

    logic bit_strobe;
    logic bit_value;
    logic eop;
    logic stuff_error;

    modport decoder (
        output bit_strobe,
        output bit_value,
        output eop,
        output stuff_error
    );

    modport control (
        input bit_strobe,
        input bit_value,
        input eop,
        input stuff_error
    );

endinterface

//--- hdl/usb_line_decoder.sv
`timescale 1ns/1ns

module usb_line_decoder #(
    parameter int CLKS_PER_BIT = 8
) (
    input logic        tb_clk,
    input logic        tb_n_rst,
    input logic        d_plus,
    input logic        d_minus,
    usb_bit_if.decoder bits
);
    import usb_rx_pkg::*;

    localparam int TW = $clog2(CLKS_PER_BIT);
    localparam logic [TW-1:0] LAST_TICK = TW'(CLKS_PER_BIT - 1);
    localparam logic [TW-1:0] HALF_TICK = TW'(CLKS_PER_BIT / 2);

    logic          dp_meta;
    logic          dp_sync;
    logic          dm_meta;
    logic          dm_sync;
    logic          dp_prev;
    logic          line_edge;
    logic [TW-1:0] timer;
    logic          sample;
    logic          se0;
    logic          nrzi_bit;
    logic          last_level;
    logic [2:0]    run;
    logic          in_packet;
    logic          se0_seen;

    // ********************
    // Synchroniser and bit timer
    // ********************

    // Line idles in J
    always_ff @(posedge tb_clk or negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            dp_meta <= 1'b1;
            dp_sync <= 1'b1;
            dm_meta <= 1'b0;
            dm_sync <= 1'b0;
            dp_prev <= 1'b1;
        end else begin
            dp_meta <= d_plus;
            dp_sync <= dp_meta;
            dm_meta <= d_minus;
            dm_sync <= dm_meta;
            dp_prev <= dp_sync;
        end
    end

    assign line_edge = dp_sync != dp_prev;

    always_ff @(posedge tb_clk or negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            timer <= '0;
        end else if (line_edge || timer == LAST_TICK) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    assign sample   = !line_edge && timer == HALF_TICK;
    assign se0      = !dp_sync && !dm_sync;
    assign nrzi_bit = dp_sync == last_level;

    // ********************
    // NRZI, unstuffing, EOP
    // ********************

    always_ff @(posedge tb_clk or negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            bits.bit_strobe  <= 1'b0;
            bits.bit_value   <= 1'b0;
            bits.eop         <= 1'b0;
            bits.stuff_error <= 1'b0;
            last_level       <= 1'b1;
            run              <= '0;
            in_packet        <= 1'b0;
            se0_seen         <= 1'b0;
        end else begin
            bits.bit_strobe  <= 1'b0;
            bits.eop         <= 1'b0;
            bits.stuff_error <= 1'b0;
            if (sample) begin
                if (se0) begin
                    if (se0_seen) begin
                        // Bus returns to J after EOP
                        bits.eop   <= 1'b1;
                        se0_seen   <= 1'b0;
                        in_packet  <= 1'b0;
                        run        <= '0;
                        last_level <= 1'b1;
                    end else begin
                        se0_seen <= 1'b1;
                    end
                end else begin
                    se0_seen   <= 1'b0;
                    last_level <= dp_sync;
                    if (run == STUFF_RUN) begin
                        run <= '0;
                        if (nrzi_bit) begin
                            bits.stuff_error <= 1'b1;
                        end
                    end else begin
                        bits.bit_strobe <= 1'b1;
                        bits.bit_value  <= nrzi_bit;
                        if (!nrzi_bit) begin
                            run       <= '0;
                            in_packet <= 1'b1;
                        end else if (in_packet) begin
                            run <= run + 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

//--- hdl/usb_rx_control.sv
`timescale 1ns/1ns

module usb_rx_control (
    input  logic                   tb_clk,
    input  logic                   tb_n_rst,
    usb_bit_if.control             bits,
    output logic [7:0]             store_byte,
    output logic                   store_strobe,
    output usb_rx_pkg::rx_packet_e rx_packet,
    output logic                   packet_done,
    output logic                   r_error
);
    import usb_rx_pkg::*;

    // SKIP waits for EOP after an error
    typedef enum logic [1:0] {
        HUNT,
        PID,
        DATA,
        SKIP
    } state_e;

    state_e     state;
    logic [7:0] shift_q;
    logic [7:0] shift_next;
    logic [2:0] bit_cnt;
    logic [1:0] fill;
    logic [7:0] dl_new;
    logic [7:0] dl_old;
    logic       byte_done;
    logic       take_byte;
    logic       pid_ok;
    rx_byte_u   cur_byte;

    function automatic rx_packet_e classify(input pid_code_e code);
        case (code)
            PID_OUT:   return PKT_OUT;
            PID_IN:    return PKT_IN;
            PID_DATA0: return PKT_DATA0;
            PID_DATA1: return PKT_DATA1;
            PID_ACK:   return PKT_ACK;
            PID_NAK:   return PKT_NAK;
            default:   return PKT_OTHER;
        endcase
    endfunction

    // LSB first, new bit enters at the top
    assign shift_next = {bits.bit_value, shift_q[7:1]};
    assign cur_byte   = shift_next;
    assign byte_done  = bits.bit_strobe && bit_cnt == 3'd7;
    assign take_byte  = state == DATA && byte_done;
    assign pid_ok     = cur_byte.pid.check == ~cur_byte.pid.code;

    // ********************
    // Packet FSM
    // ********************

    always_ff @(posedge tb_clk or negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            state        <= HUNT;
            shift_q      <= 8'hFF;
            bit_cnt      <= '0;
            fill         <= '0;
            rx_packet    <= PKT_NONE;
            packet_done  <= 1'b0;
            store_strobe <= 1'b0;
            r_error      <= 1'b0;
        end else begin
            packet_done  <= 1'b0;
            store_strobe <= 1'b0;
            if (bits.bit_strobe) begin
                shift_q <= shift_next;
                bit_cnt <= bit_cnt + 1'b1;
            end
            case (state)
                HUNT: begin
                    if (bits.bit_strobe && shift_next == SYNC_PATTERN) begin
                        state   <= PID;
                        bit_cnt <= '0;
                        fill    <= '0;
                        r_error <= 1'b0;
                    end
                end
                PID: begin
                    if (bits.stuff_error || bits.eop) begin
                        r_error <= 1'b1;
                        state   <= bits.eop ? HUNT : SKIP;
                    end else if (byte_done) begin
                        if (pid_ok) begin
                            rx_packet <= classify(cur_byte.pid.code);
                            state     <= DATA;
                        end else begin
                            r_error <= 1'b1;
                            state   <= SKIP;
                        end
                    end
                end
                DATA: begin
                    if (bits.stuff_error) begin
                        r_error <= 1'b1;
                        state   <= SKIP;
                    end else if (bits.eop) begin
                        // The two held bytes are the CRC16
                        if (bit_cnt == 3'd0) begin
                            packet_done <= 1'b1;
                        end else begin
                            r_error <= 1'b1;
                        end
                        fill  <= '0;
                        state <= HUNT;
                    end else if (take_byte) begin
                        if (fill == 2'd2) begin
                            store_strobe <= 1'b1;
                        end else begin
                            fill <= fill + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bits.eop) begin
                        state <= HUNT;
                    end
                end
            endcase
            // Idle ones must not complete a stale SYNC
            if (bits.eop) begin
                shift_q <= 8'hFF;
            end
        end
    end

    // Two-byte delay line
    always_ff @(posedge tb_clk) begin
        if (take_byte) begin
            if (fill == 2'd2) begin
                store_byte <= dl_old;
            end
            dl_old <= dl_new;
            dl_new <= cur_byte.data;
        end
    end

endmodule

//--- hdl/rx_fifo.sv
`timescale 1ns/1ns

module rx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       tb_clk,
    input  logic       tb_n_rst,
    input  logic       w_enable,
    input  logic [7:0] w_data,
    input  logic       r_enable,
    output logic [7:0] r_data,
    output logic       empty,
    output logic       full
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW-1:0] LAST_SLOT = AW'(FIFO_DEPTH - 1);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] w_ptr;
    logic [AW-1:0] r_ptr;
    logic [AW:0]   count;
    logic          do_write;
    logic          do_read;

    assign empty    = count == '0;
    assign full     = count == (AW + 1)'(FIFO_DEPTH);
    assign do_write = w_enable && !full;
    assign do_read  = r_enable && !empty;

    always_ff @(posedge tb_clk or negedge tb_n_rst) begin
        if (!tb_n_rst) begin
            w_ptr <= '0;
            r_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                w_ptr <= (w_ptr == LAST_SLOT) ? '0 : w_ptr + 1'b1;
            end
            if (do_read) begin
                r_ptr <= (r_ptr == LAST_SLOT) ? '0 : r_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and read register
    always_ff @(posedge tb_clk) begin
        if (do_write) begin
            mem[w_ptr] <= w_data;
        end
        if (do_read) begin
            r_data <= mem[r_ptr];
        end
    end

endmodule

//--- hdl/usb_rx_top.sv
`timescale 1ns/1ns

module usb_rx_top #(
    parameter int CLKS_PER_BIT = 8,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                   tb_clk,
    input  logic                   tb_n_rst,
    input  logic                   d_plus,
    input  logic                   d_minus,
    input  logic                   r_enable,
    output logic [7:0]             r_data,
    output logic                   empty,
    output logic                   full,
    output usb_rx_pkg::rx_packet_e rx_packet,
    output logic                   packet_done,
    output logic                   r_error
);

    logic [7:0] store_byte;
    logic       store_strobe;

    usb_bit_if bits_if ();

    usb_line_decoder #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) line_decoder_i (
        .tb_clk  (tb_clk),
        .tb_n_rst(tb_n_rst),
        .d_plus  (d_plus),
        .d_minus (d_minus),
        .bits    (bits_if.decoder)
    );

    usb_rx_control rx_control_i (
        .tb_clk      (tb_clk),
        .tb_n_rst    (tb_n_rst),
        .bits        (bits_if.control),
        .store_byte  (store_byte),
        .store_strobe(store_strobe),
        .rx_packet   (rx_packet),
        .packet_done (packet_done),
        .r_error     (r_error)
    );

    // Writes while full are dropped inside the FIFO
    rx_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_fifo_i (
        .tb_clk  (tb_clk),
        .tb_n_rst(tb_n_rst),
        .w_enable(store_strobe),
        .w_data  (store_byte),
        .r_enable(r_enable),
        .r_data  (r_data),
        .empty   (empty),
        .full    (full)
    );

endmodule

//--- verif/usb_rx_properties.sv
`timescale 1ns/1ns

module usb_rx_properties (
    input logic tb_clk,
    input logic tb_n_rst,
    input logic empty,
    input logic full,
    input logic packet_done,
    input logic r_error
);

    int fail_count = 0;

    a_empty_full: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        !(empty && full))
        else begin
            fail_count++;
            $error("FIFO shows empty and full together");
        end

    // packet_done is a single-cycle strobe
    a_done_pulse: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        packet_done |=> !packet_done)
        else begin
            fail_count++;
            $error("packet_done high for more than one cycle");
        end

    a_done_no_error: assert property (@(posedge tb_clk) disable iff (!tb_n_rst)
        $rose(packet_done) |-> !r_error)
        else begin
            fail_count++;
            $error("packet_done rose while r_error was high");
        end

endmodule

bind usb_rx_top usb_rx_properties usb_rx_properties_i (
    .tb_clk     (tb_clk),
    .tb_n_rst   (tb_n_rst),
    .empty      (empty),
    .full       (full),
    .packet_done(packet_done),
    .r_error    (r_error)
);

//--- verif/tb_usb_rx.sv
`timescale 1ns/1ns

module tb_usb_rx;
    import usb_rx_pkg::*;

    localparam int BIT_CLKS   = 8;
    localparam int FIFO_DEPTH = 8;
    localparam int WAIT_LIMIT = 600;

    typedef logic [7:0] byte_q_t [$];

    logic       tb_clk;
    logic       tb_n_rst;
    logic       d_plus;
    logic       d_minus;
    logic       r_enable;
    logic [7:0] r_data;
    logic       empty;
    logic       full;
    rx_packet_e rx_packet;
    logic       packet_done;
    logic       r_error;

    logic        line_level;
    int          ones;
    logic [31:0] rng_state;
    string       test_name = "reset";
    rx_packet_e  exp_packet = PKT_NONE;
    int          done_count = 0;

    usb_rx_top usb_rx_top_i (.*);

    initial begin
        tb_clk = 1'b0;
        forever #5 tb_clk = ~tb_clk;
    end

    // ********************
    // Reference model
    // ********************

    // All bytes after the PID except the trailing CRC16
    function automatic byte_q_t expected_bytes(input byte_q_t sent);
        byte_q_t kept;
        for (int i = 0; i < sent.size() - 2; i++) begin
            kept.push_back(sent[i]);
        end
        return kept;
    endfunction

    function automatic rx_packet_e expected_packet(input logic [3:0] code);
        case (code)
            4'b0001: return PKT_OUT;
            4'b1001: return PKT_IN;
            4'b0011: return PKT_DATA0;
            4'b1011: return PKT_DATA1;
            4'b0010: return PKT_ACK;
            4'b1010: return PKT_NAK;
            default: return PKT_OTHER;
        endcase
    endfunction

    function automatic logic [7:0] pid_byte(input logic [3:0] code);
        return {~code, code};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ********************
    // Checks
    // ********************

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] expected,
                              input logic [7:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %02h, actual %02h", name, expected, actual));
        end
    endtask

    task automatic check_packet(input string name, input rx_packet_e expected,
                                input rx_packet_e actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %s, actual %s", name, expected.name(),
                               actual.name()));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            fail_run($sformatf("FAILED %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // Compares the packet class at every packet_done
    always @(posedge tb_clk) begin
        if (packet_done) begin
            check_packet({test_name, " packet class"}, exp_packet, rx_packet);
            done_count++;
        end
        if (usb_rx_top_i.usb_rx_properties_i.fail_count != 0) begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

    task automatic wait_event(input string what, input int target);
        int   cycles;
        logic met;
        cycles = 0;
        do begin
            @(negedge tb_clk);
            cycles++;
            if (what == "packet_done") begin
                met = done_count >= target;
            end else if (what == "r_error") begin
                met = r_error;
            end else begin
                met = empty;
            end
        end while (!met && cycles < WAIT_LIMIT);
        if (!met) begin
            fail_run({"timed out in ", test_name, " waiting for ", what});
        end
    endtask

    task automatic drain_fifo(input byte_q_t exp_q);
        foreach (exp_q[i]) begin
            @(negedge tb_clk);
            check_flag({test_name, " empty before pop"}, 1'b0, empty);
            @(posedge tb_clk);
            r_enable <= 1'b1;
            @(posedge tb_clk);
            r_enable <= 1'b0;
            @(negedge tb_clk);
            check_byte({test_name, " data"}, exp_q[i], r_data);
        end
        wait_event("empty", 0);
    endtask

    // ********************
    // Host line model
    // ********************

    task automatic drive_line(input logic dp, input logic dm);
        @(posedge tb_clk);
        d_plus  <= dp;
        d_minus <= dm;
        repeat (BIT_CLKS - 1) @(posedge tb_clk);
    endtask

    // NRZI: a zero toggles the line, a one holds it
    task automatic send_bit(input logic b, input logic stuff_on);
        if (!b) begin
            line_level = !line_level;
        end
        drive_line(line_level, !line_level);
        ones = b ? ones + 1 : 0;
        if (stuff_on && ones == 6) begin
            line_level = !line_level;
            drive_line(line_level, !line_level);
            ones = 0;
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        for (int i = 0; i < 8; i++) begin
            send_bit(value[i], 1'b1);
        end
    endtask

    // Raw ones go out unstuffed after the payload
    task automatic send_packet(input logic [7:0] pid, input byte_q_t payload,
                               input int raw_ones);
        ones = 0;
        send_byte(8'h80);
        send_byte(pid);
        foreach (payload[i]) begin
            send_byte(payload[i]);
        end
        repeat (raw_ones) send_bit(1'b1, 1'b0);
        drive_line(1'b0, 1'b0);
        drive_line(1'b0, 1'b0);
        line_level = 1'b1;
        drive_line(1'b1, 1'b0);
    endtask

    task automatic receive_good(input string name, input logic [3:0] code,
                                input byte_q_t payload);
        int base;
        base       = done_count;
        test_name  = name;
        exp_packet = expected_packet(code);
        send_packet(pid_byte(code), payload, 0);
        wait_event("packet_done", base + 1);
        check_flag({name, " r_error"}, 1'b0, r_error);
        drain_fifo(expected_bytes(payload));
    endtask

    // ********************
    // Test sequence
    // ********************

    initial begin
        byte_q_t    payload;
        byte_q_t    all_q;
        byte_q_t    kept_q;
        int         len;
        int         base;
        tb_n_rst   = 1'b0;
        d_plus     = 1'b1;
        d_minus    = 1'b0;
        r_enable   = 1'b0;
        line_level = 1'b1;
        ones       = 0;
        rng_state  = 32'h0384_5e76;
        repeat (2) @(posedge tb_clk);
        tb_n_rst <= 1'b1;

        @(negedge tb_clk);
        check_flag("reset empty", 1'b1, empty);
        check_flag("reset full", 1'b0, full);
        check_packet("reset rx_packet", PKT_NONE, rx_packet);
        check_flag("reset r_error", 1'b0, r_error);
        check_flag("reset packet_done", 1'b0, packet_done);

        for (int n = 0; n < 6; n++) begin
            payload = {};
            len = int'(next_random() % 32'd6) + 3;
            for (int i = 0; i < len; i++) begin
                payload.push_back(8'(next_random()));
            end
            receive_good($sformatf("random packet %0d", n), n[0] ? 4'b1011 : 4'b0011,
                         payload);
        end
        payload = {};
        receive_good("ack", 4'b0010, payload);

        // Long runs of ones force stuffed zeros
        payload = {8'hFF, 8'hFF, 8'h7E, 8'h7E, 8'hFF, 8'h7E};
        payload.push_back(8'(next_random()));
        payload.push_back(8'(next_random()));
        receive_good("bit stuffing", 4'b1011, payload);

        // Check nibble of zero does not match DATA0
        test_name = "bad pid";
        base = done_count;
        send_packet(8'h03, payload, 0);
        wait_event("r_error", 0);
        repeat (4) @(negedge tb_clk);
        check_flag("bad pid packet_done", 1'b0, done_count != base);
        check_flag("bad pid empty", 1'b1, empty);
        receive_good("after bad pid", 4'b0011, payload);

        test_name = "stuff error";
        payload = {};
        for (int i = 0; i < 5; i++) begin
            payload.push_back(8'(next_random()));
        end
        base = done_count;
        send_packet(pid_byte(4'b1011), payload, 7);
        wait_event("r_error", 0);
        repeat (4) @(negedge tb_clk);
        check_flag("stuff error packet_done", 1'b0, done_count != base);
        drain_fifo(expected_bytes(payload));

        // No reads while the packet arrives
        test_name  = "overflow";
        exp_packet = expected_packet(4'b0011);
        payload    = {};
        for (int i = 0; i < 12; i++) begin
            payload.push_back(8'(next_random()));
        end
        base = done_count;
        send_packet(pid_byte(4'b0011), payload, 0);
        wait_event("packet_done", base + 1);
        check_flag("overflow full", 1'b1, full);
        all_q  = expected_bytes(payload);
        kept_q = {};
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            kept_q.push_back(all_q[i]);
        end
        drain_fifo(kept_q);

        if (usb_rx_top_i.usb_rx_properties_i.fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run("a bound assertion on the DUT failed");
        end
    end

endmodule

//--- verilog.f
hdl/usb_rx_pkg.sv
hdl/usb_bit_if.sv
hdl/usb_line_decoder.sv
hdl/usb_rx_control.sv
hdl/rx_fifo.sv
hdl/usb_rx_top.sv
verif/usb_rx_properties.sv
verif/tb_usb_rx.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds with Verilator, runs the testbench and checks the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_usb_rx -f verilog.f -o tb_usb_rx \
    && { ./obj_dir/tb_usb_rx +verilator+error+limit+100 > sim.log 2>&1; cat sim.log; } \
    || { echo "Verilator build failed"; exit 1; }
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
